//--- uno_card_pkg.sv
package uno_card_pkg;

    typedef enum logic [1:0] {
        COLOR_RED    = 2'd0,
        COLOR_YELLOW = 2'd1,
        COLOR_GREEN  = 2'd2,
        COLOR_BLUE   = 2'd3
    } color_e;

    // value 0-9 number, 10-12 action, 13 wild, 14 wild draw four
    typedef struct packed {
        color_e     color;
        logic [3:0] value;
    } card_t;

    localparam logic [3:0] VAL_WILD   = 4'd13;
    localparam logic [3:0] VAL_WILD4  = 4'd14;
    localparam logic [3:0] ACTION_MIN = 4'd10;

    localparam int ACTION_POINTS = 20;
    localparam int WILD_POINTS   = 50;
    localparam int NUM_VALUES    = 13; // colored values only

    typedef struct packed {
        logic [3:0][NUM_VALUES-1:0] present; // [color][value]
        logic                       wild_present;
        logic                       wild4_present;
    } hand_summary_t;

endpackage

//--- uno_ctrl_pkg.sv
package uno_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_DRAW        = 3'd1,
        ST_SELECT      = 3'd2,
        ST_PLAY        = 3'd3,
        ST_FORCED_DRAW = 3'd4
    } turn_state_e;

    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_ADD    = 2'd1,
        OP_REMOVE = 2'd2
    } hand_op_e;

    typedef struct packed {
        hand_op_e            op;
        uno_card_pkg::card_t card;
    } hand_cmd_t;

    typedef struct packed {
        logic                valid;
        uno_card_pkg::card_t card;
    } choice_t;

endpackage

//--- hand_store.sv
`timescale 1ns/1ns

module hand_store #(
    parameter int HAND_NUM_W = 7,
    parameter int SCORE_W    = 11
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  uno_ctrl_pkg::hand_cmd_t     i_cmd,
    output uno_card_pkg::hand_summary_t o_summary,
    output logic [HAND_NUM_W-1:0]       o_hand_num,
    output logic [SCORE_W-1:0]          o_score
);

    // copies held per color and value
    logic [3:0][uno_card_pkg::NUM_VALUES-1:0][1:0] cnt_r;
    logic [1:0] wild_cnt_r;  // up to three of each wild kind
    logic [1:0] wild4_cnt_r;
    logic [5:0] card_pts;
    logic       is_wild;
    logic       is_wild4;

    assign is_wild  = (i_cmd.card.value == uno_card_pkg::VAL_WILD);
    assign is_wild4 = (i_cmd.card.value == uno_card_pkg::VAL_WILD4);

    always_comb begin
        if (is_wild || is_wild4) begin
            card_pts = 6'(uno_card_pkg::WILD_POINTS);
        end else if (i_cmd.card.value >= uno_card_pkg::ACTION_MIN) begin
            card_pts = 6'(uno_card_pkg::ACTION_POINTS);
        end else begin
            card_pts = {2'b00, i_cmd.card.value}; // numbers score face value
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_r       <= '0;
            wild_cnt_r  <= 2'd0;
            wild4_cnt_r <= 2'd0;
            o_hand_num  <= '0;
            o_score     <= '0;
        end else begin
            case (i_cmd.op)
                uno_ctrl_pkg::OP_ADD: begin
                    if (is_wild) begin
                        wild_cnt_r <= wild_cnt_r + 2'd1; // color field ignored
                    end else if (is_wild4) begin
                        wild4_cnt_r <= wild4_cnt_r + 2'd1;
                    end else begin
                        cnt_r[i_cmd.card.color][i_cmd.card.value] <=
                            cnt_r[i_cmd.card.color][i_cmd.card.value] + 2'd1;
                    end
                    o_hand_num <= o_hand_num + HAND_NUM_W'(1);
                    o_score    <= o_score + SCORE_W'(card_pts);
                end
                uno_ctrl_pkg::OP_REMOVE: begin
                    if (is_wild) begin
                        wild_cnt_r <= wild_cnt_r - 2'd1;
                    end else if (is_wild4) begin
                        wild4_cnt_r <= wild4_cnt_r - 2'd1;
                    end else begin
                        cnt_r[i_cmd.card.color][i_cmd.card.value] <=
                            cnt_r[i_cmd.card.color][i_cmd.card.value] - 2'd1;
                    end
                    o_hand_num <= o_hand_num - HAND_NUM_W'(1);
                    o_score    <= o_score - SCORE_W'(card_pts);
                end
                default: ;
            endcase
        end
    end

    // presence is just a non-zero count
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < uno_card_pkg::NUM_VALUES; v++) begin
                o_summary.present[c][v] = |cnt_r[c][v];
            end
        end
        o_summary.wild_present  = |wild_cnt_r;
        o_summary.wild4_present = |wild4_cnt_r;
    end

endmodule

//--- play_chooser.sv
`timescale 1ns/1ns

module play_chooser (
    input  uno_card_pkg::hand_summary_t i_summary,
    input  uno_card_pkg::card_t         i_prev_card,
    output uno_ctrl_pkg::choice_t       o_choice
);

    logic                 color_hit;
    logic [3:0]           color_val;
    logic                 num_hit;
    uno_card_pkg::color_e num_color;

    // lowest value in the previous color
    // a wild on the pile carries its declared color
    always_comb begin
        color_hit = 1'b0;
        color_val = 4'd0;
        for (int v = uno_card_pkg::NUM_VALUES - 1; v >= 0; v--) begin
            if (i_summary.present[i_prev_card.color][v]) begin
                color_hit = 1'b1;
                color_val = 4'(v);
            end
        end
    end

    // same value in another color with red first
    always_comb begin
        num_hit   = 1'b0;
        num_color = uno_card_pkg::COLOR_RED;
        if (i_prev_card.value < 4'(uno_card_pkg::NUM_VALUES)) begin
            for (int c = 3; c >= 0; c--) begin
                if (i_summary.present[c][i_prev_card.value]) begin
                    num_hit   = 1'b1;
                    num_color = uno_card_pkg::color_e'(c);
                end
            end
        end
    end

    always_comb begin
        o_choice = '0;
        if (color_hit) begin
            o_choice.valid      = 1'b1;
            o_choice.card.color = i_prev_card.color;
            o_choice.card.value = color_val;
        end else if (num_hit) begin
            o_choice.valid      = 1'b1;
            o_choice.card.color = num_color;
            o_choice.card.value = i_prev_card.value;
        end else if (i_summary.wild_present) begin
            o_choice.valid      = 1'b1;
            o_choice.card.value = uno_card_pkg::VAL_WILD; // color set later by the FSM
        end else if (i_summary.wild4_present) begin
            o_choice.valid      = 1'b1;
            o_choice.card.value = uno_card_pkg::VAL_WILD4;
        end
    end

endmodule

//--- turn_fsm.sv
`timescale 1ns/1ns

module turn_fsm (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_init,
    input  logic                        i_start,
    input  logic                        i_draw_two,
    input  logic                        i_draw_four,
    input  logic                        i_drawn,
    input  uno_card_pkg::card_t         i_drawn_card,
    input  logic                        i_check,
    input  uno_ctrl_pkg::choice_t       i_choice,
    input  uno_card_pkg::hand_summary_t i_summary,
    output uno_ctrl_pkg::hand_cmd_t     o_cmd,
    output logic                        o_draw_card,
    output logic                        o_out,
    output uno_card_pkg::card_t         o_out_card,
    output logic                        o_turn_done
);

    uno_ctrl_pkg::turn_state_e state_r, state_nxt;
    logic [2:0]                draw_cnt_r, draw_cnt_nxt; // cards still owed
    logic                      deal_r, deal_nxt;         // draw is the initial deal
    uno_card_pkg::card_t       out_card_r;
    uno_card_pkg::card_t       offer_card;
    logic                      take_card;

    assign take_card   = o_draw_card && i_drawn;
    assign o_draw_card = (state_r == uno_ctrl_pkg::ST_DRAW) ||
                         (state_r == uno_ctrl_pkg::ST_FORCED_DRAW);
    assign o_out       = (state_r == uno_ctrl_pkg::ST_PLAY);
    assign o_out_card  = out_card_r;

    // declared wild color is the first color still held or else red
    always_comb begin
        offer_card = i_choice.card;
        if (i_choice.card.value >= uno_card_pkg::VAL_WILD) begin
            offer_card.color = uno_card_pkg::COLOR_RED;
            for (int c = 3; c >= 0; c--) begin
                if (|i_summary.present[c]) begin
                    offer_card.color = uno_card_pkg::color_e'(c);
                end
            end
        end
    end

    always_comb begin
        o_cmd = '0;
        if (take_card) begin
            o_cmd.op   = uno_ctrl_pkg::OP_ADD;
            o_cmd.card = i_drawn_card;
        end else if (state_r == uno_ctrl_pkg::ST_SELECT && i_choice.valid) begin
            o_cmd.op   = uno_ctrl_pkg::OP_REMOVE;
            o_cmd.card = i_choice.card;
        end
    end

    always_comb begin
        state_nxt    = state_r;
        draw_cnt_nxt = draw_cnt_r;
        deal_nxt     = deal_r;
        case (state_r)
            uno_ctrl_pkg::ST_IDLE: begin
                if (i_start) begin
                    deal_nxt = 1'b0;
                    if (i_draw_two || i_draw_four) begin
                        state_nxt    = uno_ctrl_pkg::ST_DRAW;
                        draw_cnt_nxt = i_draw_two ? 3'd2 : 3'd4;
                    end else begin
                        state_nxt = uno_ctrl_pkg::ST_SELECT;
                    end
                end else if (i_init) begin
                    state_nxt    = uno_ctrl_pkg::ST_DRAW;
                    draw_cnt_nxt = 3'd7;
                    deal_nxt     = 1'b1;
                end
            end
            uno_ctrl_pkg::ST_DRAW: begin
                if (take_card) begin
                    draw_cnt_nxt = draw_cnt_r - 3'd1;
                    if (draw_cnt_r == 3'd1) begin
                        state_nxt = deal_r ? uno_ctrl_pkg::ST_IDLE : uno_ctrl_pkg::ST_SELECT;
                    end
                end
            end
            uno_ctrl_pkg::ST_SELECT: begin
                state_nxt = i_choice.valid ? uno_ctrl_pkg::ST_PLAY : uno_ctrl_pkg::ST_FORCED_DRAW;
            end
            uno_ctrl_pkg::ST_PLAY: begin
                if (i_check) begin
                    state_nxt = uno_ctrl_pkg::ST_IDLE;
                end
            end
            uno_ctrl_pkg::ST_FORCED_DRAW: begin
                if (take_card) begin
                    state_nxt = uno_ctrl_pkg::ST_IDLE;
                end
            end
            default: state_nxt = uno_ctrl_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= uno_ctrl_pkg::ST_IDLE;
            draw_cnt_r  <= 3'd0;
            deal_r      <= 1'b0;
            o_turn_done <= 1'b0;
        end else begin
            state_r     <= state_nxt;
            draw_cnt_r  <= draw_cnt_nxt;
            deal_r      <= deal_nxt;
            // one pulse on the first idle cycle
            o_turn_done <= (state_nxt == uno_ctrl_pkg::ST_IDLE) &&
                           (state_r != uno_ctrl_pkg::ST_IDLE);
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == uno_ctrl_pkg::ST_SELECT) begin
            out_card_r <= offer_card;
        end
    end

endmodule

//--- uno_player_top.sv
`timescale 1ns/1ns

module uno_player_top #(
    parameter int HAND_NUM_W = 7,
    parameter int SCORE_W    = 11
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_init,
    input  logic                  i_start,
    input  logic                  i_draw_two,
    input  logic                  i_draw_four,
    input  uno_card_pkg::card_t   i_prev_card,
    input  logic                  i_drawn,
    input  uno_card_pkg::card_t   i_drawn_card,
    input  logic                  i_check,
    output logic                  o_draw_card,
    output logic                  o_out,
    output uno_card_pkg::card_t   o_out_card,
    output logic [HAND_NUM_W-1:0] o_hand_num,
    output logic [SCORE_W-1:0]    o_score,
    output logic                  o_turn_done
);

    uno_ctrl_pkg::hand_cmd_t     hand_cmd;
    uno_card_pkg::hand_summary_t hand_summary;
    uno_ctrl_pkg::choice_t       choice;

    hand_store #(
        .HAND_NUM_W (HAND_NUM_W),
        .SCORE_W    (SCORE_W)
    ) hand_store_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (hand_cmd),
        .o_summary  (hand_summary),
        .o_hand_num (o_hand_num),
        .o_score    (o_score)
    );

    play_chooser play_chooser_i (
        .i_summary   (hand_summary),
        .i_prev_card (i_prev_card),
        .o_choice    (choice)
    );

    turn_fsm turn_fsm_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init       (i_init),
        .i_start      (i_start),
        .i_draw_two   (i_draw_two),
        .i_draw_four  (i_draw_four),
        .i_drawn      (i_drawn),
        .i_drawn_card (i_drawn_card),
        .i_check      (i_check),
        .i_choice     (choice),
        .i_summary    (hand_summary),
        .o_cmd        (hand_cmd),
        .o_draw_card  (o_draw_card),
        .o_out        (o_out),
        .o_out_card   (o_out_card),
        .o_turn_done  (o_turn_done)
    );

endmodule

//--- uno_player_asserts.sv
`timescale 1ns/1ns

module uno_player_asserts (
    input logic                i_clk,
    input logic                i_rst_n,
    input logic                i_check,
    input logic                o_draw_card,
    input logic                o_out,
    input uno_card_pkg::card_t o_out_card,
    input logic                o_turn_done
);

    int n_excl = 0;
    int n_stable = 0;
    int n_done = 0;
    int n_reset = 0;
    int fail_cnt;

    assign fail_cnt = n_excl + n_stable + n_done + n_reset;

    a_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_draw_card && o_out))
        else begin
            $error("draw request and card offer are high together");
            n_excl++;
        end

    // offered card held until the play is checked
    a_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_out && !i_check) |=> (o_out && $stable(o_out_card)))
        else begin
            $error("offered card changed before the check");
            n_stable++;
        end

    a_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_turn_done |=> !o_turn_done)
        else begin
            $error("turn done lasted more than one cycle");
            n_done++;
        end

    a_reset: assert property (@(posedge i_clk)
        $rose(i_rst_n) |-> !(o_out || o_draw_card || o_turn_done))
        else begin
            $error("control outputs not low on the first edge after reset");
            n_reset++;
        end

endmodule

//--- uno_checker.sv
`timescale 1ns/1ns

module uno_checker #(
    parameter int HAND_NUM_W = 7,
    parameter int SCORE_W    = 11
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_init,
    input  logic                  i_start,
    input  logic                  i_draw_two,
    input  logic                  i_draw_four,
    input  uno_card_pkg::card_t   i_prev_card,
    input  logic                  i_drawn,
    input  uno_card_pkg::card_t   i_drawn_card,
    input  logic                  i_check,
    input  logic                  o_draw_card,
    input  logic                  o_out,
    input  uno_card_pkg::card_t   o_out_card,
    input  logic [HAND_NUM_W-1:0] o_hand_num,
    input  logic [SCORE_W-1:0]    o_score,
    input  logic                  o_turn_done,
    output int                    o_tests,
    output int                    o_errors
);

    int cnt [4][13];  // mirror of the hand by [color][value]
    int wcnt [2];     // wild and wild draw four
    int num;
    int score;
    int owed;
    int extra;        // cards taken after the choice
    int tests = 0;
    int errors = 0;
    int base = 0;
    bit busy, deal, penalty, chosen, played;
    string name = "reset";
    uno_ctrl_pkg::choice_t exp_r;

    assign o_tests  = tests;
    assign o_errors = errors;

    function automatic int points(input uno_card_pkg::card_t c);
        if (c.value >= 4'd13) return uno_card_pkg::WILD_POINTS;
        if (c.value >= 4'd10) return uno_card_pkg::ACTION_POINTS;
        return int'(c.value);
    endfunction

    task automatic update(input uno_card_pkg::card_t c, input int d);
        if (c.value == 4'd13) wcnt[0] += d;
        else if (c.value == 4'd14) wcnt[1] += d;
        else cnt[c.color][c.value] += d;  // wild color does not matter
        num += d;
        score += d * points(c);
    endtask

    function automatic uno_card_pkg::color_e wild_color();
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < 13; v++) begin
                if (cnt[2'(c)][4'(v)] > 0) return uno_card_pkg::color_e'(2'(c));
            end
        end
        return uno_card_pkg::COLOR_RED;
    endfunction

    // expected play is own color, then same value, then wild, then wild draw four
    function automatic uno_ctrl_pkg::choice_t ref_choice(input uno_card_pkg::card_t prev);
        uno_ctrl_pkg::choice_t ch;
        ch = '0;
        for (int v = 0; v < 13; v++) begin
            if (cnt[prev.color][4'(v)] > 0) begin
                ch.valid = 1'b1;
                ch.card.color = prev.color;
                ch.card.value = 4'(v);
                return ch;
            end
        end
        if (prev.value <= 4'd12) begin
            for (int c = 0; c < 4; c++) begin
                if (cnt[2'(c)][prev.value] > 0) begin
                    ch.valid = 1'b1;
                    ch.card.color = uno_card_pkg::color_e'(2'(c));
                    ch.card.value = prev.value;
                    return ch;
                end
            end
        end
        if (wcnt[0] > 0 || wcnt[1] > 0) begin
            ch.valid = 1'b1;
            ch.card.color = wild_color();
            ch.card.value = (wcnt[0] > 0) ? 4'd13 : 4'd14;
        end
        return ch;
    endfunction

    task automatic value_error(input string what, input int expected, input int actual);
        $display("[ERROR] %s %s: expected %0d, actual %0d", name, what, expected, actual);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", name, msg);
        errors++;
    endtask

    task automatic finish_test();
        if (!busy) report_problem("turn done seen without a turn in progress");
        if (owed != 0) report_problem("turn ended before all owed cards were taken");
        if (!chosen && extra != 0) report_problem("more cards taken than were owed");
        if (chosen && exp_r.valid && (!played || extra != 0))
            report_problem("the expected card was not played");
        if (chosen && !exp_r.valid && (played || extra != 1))
            report_problem("turn without a playable card did not take exactly one card");
        if (int'(o_hand_num) != num) value_error("hand count", num, int'(o_hand_num));
        if (int'(o_score) != score) value_error("score", score, int'(o_score));
        $display("%s %s", name, (errors == base) ? "ok" : "failed");
        tests++;
        base = errors;
        busy = 1'b0;
    endtask

    always @(negedge i_clk) begin
        string kind;
        if (!i_rst_n) begin
            cnt = '{default: '{default: 0}};
            wcnt = '{default: 0};
            num = 0;
            score = 0;
            busy = 1'b0;
            if (o_draw_card || o_out || o_turn_done || o_hand_num != '0 || o_score != '0)
                report_problem("outputs not cleared during reset");
        end else begin
            if (o_turn_done) finish_test();
            if (!busy && (i_start || i_init)) begin
                busy    = 1'b1;
                deal    = !i_start;
                owed    = !i_start ? 7 : i_draw_two ? 2 : i_draw_four ? 4 : 0;
                penalty = i_start && (i_draw_two || i_draw_four);
                chosen  = 1'b0;
                played  = 1'b0;
                extra   = 0;
                name    = $sformatf("turn%0d_%s", tests, deal ? "reset_and_deal" : "turn");
            end
            if (o_draw_card && i_drawn) begin  // taken at the next rising edge
                update(i_drawn_card, 1);
                if (owed > 0) owed--;
                else extra++;
            end
            if (busy && !deal && !chosen && owed == 0) begin
                exp_r  = ref_choice(i_prev_card);
                chosen = 1'b1;
                kind = !exp_r.valid ? "no_play" :
                       (exp_r.card.value == 4'd13) ? "wild" :
                       (exp_r.card.value == 4'd14) ? "wild_draw_four" :
                       (exp_r.card.color == i_prev_card.color) ? "color_match" : "number_match";
                name = $sformatf("turn%0d_%s%s", tests, penalty ? "penalty_" : "", kind);
            end
            if (o_out) begin
                if (!chosen || !exp_r.valid)
                    report_problem("card offered although none was playable");
                else if (o_out_card != exp_r.card)
                    value_error("offered card", int'(exp_r.card), int'(o_out_card));
                if (i_check && chosen && exp_r.valid && !played) begin
                    update(exp_r.card, -1);
                    played = 1'b1;
                end
            end
        end
    end

endmodule

//--- tb_uno_player.sv
`timescale 1ns/1ns

module tb_uno_player;

    localparam int HAND_NUM_W = 7;
    localparam int SCORE_W    = 11;
    localparam int NUM_TURNS  = 40;  // the deal plus 39 turns
    localparam int MAX_CYCLES = NUM_TURNS * 64;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_init, i_start, i_draw_two, i_draw_four;
    uno_card_pkg::card_t   i_prev_card;
    logic                  i_drawn;
    uno_card_pkg::card_t   i_drawn_card;
    logic                  i_check;
    logic                  o_draw_card, o_out, o_turn_done;
    uno_card_pkg::card_t   o_out_card;
    logic [HAND_NUM_W-1:0] o_hand_num;
    logic [SCORE_W-1:0]    o_score;
    int                    tests, errors;
    int                    cycles = 0;
    logic [31:0]           lfsr_r = 32'h6402;
    int                    held [4][13];  // copies given to the DUT and not yet played
    int                    held_w [2];

    always #4 i_clk = ~i_clk;

    uno_player_top #(.HAND_NUM_W(HAND_NUM_W), .SCORE_W(SCORE_W)) dut_i (.*);

    uno_checker #(.HAND_NUM_W(HAND_NUM_W), .SCORE_W(SCORE_W)) checker_i (
        .o_tests  (tests),
        .o_errors (errors),
        .*
    );

    bind uno_player_top uno_player_asserts asserts_i (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_r = lfsr_step(lfsr_r);
            r = (r << 1) | int'(lfsr_r[0]);
        end
        return r;
    endfunction

    // skips cards the hand already holds the maximum copies of
    function automatic uno_card_pkg::card_t next_card();
        uno_card_pkg::card_t c;
        int v;
        int k;
        do begin
            v = rand_bits(4);
            k = rand_bits(2);
        end while (v > 14 || (v >= 13 && ((v == 13) ? held_w[0] : held_w[1]) >= 3) ||
                   (v < 13 && held[2'(k)][4'(v)] >= 2));
        c.color = uno_card_pkg::color_e'(2'(k));
        c.value = 4'(v);
        return c;
    endfunction

    task automatic count_held(input uno_card_pkg::card_t c, input int d);
        if (c.value == 4'd13) held_w[0] += d;
        else if (c.value == 4'd14) held_w[1] += d;
        else held[c.color][c.value] += d;
    endtask

    task automatic run_turn(input logic init, input logic two, input logic four,
                            input uno_card_pkg::card_t prev);
        int delay;
        logic done, take, play, want_draw, want_play;
        uno_card_pkg::card_t out_c;
        uno_card_pkg::card_t c;
        @(posedge i_clk);
        i_init      <= init;
        i_start     <= !init;
        i_draw_two  <= two;
        i_draw_four <= four;
        i_prev_card <= prev;
        @(posedge i_clk);
        i_init      <= 1'b0;
        i_start     <= 1'b0;
        i_draw_two  <= 1'b0;
        i_draw_four <= 1'b0;
        delay = rand_bits(2);
        done = 1'b0;
        while (!done) begin
            @(negedge i_clk);  // outputs settled here
            done      = o_turn_done;
            take      = o_draw_card && i_drawn;
            play      = o_out && i_check;
            want_draw = o_draw_card && !i_drawn;
            want_play = o_out && !i_check;
            out_c     = o_out_card;
            if (!done) begin
                @(posedge i_clk);
                if (take) begin
                    i_drawn <= 1'b0;
                    delay = rand_bits(2);
                end
                if (play) begin
                    i_check <= 1'b0;
                    count_held(out_c, -1);
                end
                if (want_draw || want_play) begin
                    if (delay > 0) begin
                        delay--;  // back-pressure
                    end else if (want_draw) begin
                        c = next_card();
                        count_held(c, 1);
                        i_drawn_card <= c;
                        i_drawn      <= 1'b1;
                    end else begin
                        i_check <= 1'b1;
                    end
                end
            end
        end
    endtask

    initial begin
        uno_card_pkg::card_t prev;
        int pick;
        i_rst_n      = 1'b0;
        i_init       = 1'b0;
        i_start      = 1'b0;
        i_draw_two   = 1'b0;
        i_draw_four  = 1'b0;
        i_prev_card  = '0;
        i_drawn      = 1'b0;
        i_drawn_card = '0;
        i_check      = 1'b0;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        run_turn(1'b1, 1'b0, 1'b0, '0);
        for (int t = 1; t < NUM_TURNS; t++) begin
            prev.color = uno_card_pkg::color_e'(2'(rand_bits(2)));
            prev.value = 4'(rand_bits(4) % 15);  // wild on the pile keeps its declared color
            pick = rand_bits(3);
            run_turn(1'b0, pick == 0, pick == 1, prev);
        end
        repeat (2) @(posedge i_clk);
        $display("%0d tests, %0d errors, %0d assertion failures", tests, errors,
                 dut_i.asserts_i.fail_cnt);
        if (errors == 0 && tests == NUM_TURNS && dut_i.asserts_i.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

//--- filelist.f
uno_card_pkg.sv
uno_ctrl_pkg.sv
hand_store.sv
play_chooser.sv
turn_fsm.sv
uno_player_top.sv
uno_player_asserts.sv
uno_checker.sv
tb_uno_player.sv

//--- run.sh
#!/bin/sh
# builds and runs the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_uno_player -o sim_tb

# keep running past assertion errors so the testbench prints its verdict
./obj_dir/sim_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "TB PASSED" sim.log; then
    exit 0
else
    exit 1
fi
